// ==== source/decode_pkg.sv ====
// Shared widths, opcodes, select encodings and records of the decode stage
// Every design file refers to these by scoped names

package decode_pkg;

  ////////////////////
  // Widths and field positions
  ////////////////////
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_RS     = 2;
  localparam int OPC_W      = 7;
  localparam int FUNCT3_W   = 3;
  localparam int FUNCT7_W   = 7;
  localparam int LSU_SIZE_W = 2;

  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int FUNCT7_LSB = 25;

  // Link value added to the PC by JAL and JALR
  localparam int PC_INCR = 4;

  ////////////////////
  // Major opcodes of the supported subset
  ////////////////////
  localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;
  localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
  localparam logic [OPC_W-1:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [OPC_W-1:0] OPC_LOAD   = 7'b0000011;
  localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;
  localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
  localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
  localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;

  // funct7 of the plain and the alternate (SUB, SRA) operations
  localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
  localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;

  ////////////////////
  // Encodings
  ////////////////////
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;
  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM, OP_B_PCINCR} op_b_sel_e;
  typedef enum logic [1:0] {OP_C_RS2, OP_C_TARGET, OP_C_NONE} op_c_sel_e;

  ////////////////////
  // Records
  ////////////////////
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
  } if_id_t;

  // One writeback source seen by the bypass units
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } fwd_src_t;

  typedef struct packed {
    alu_op_e               alu_op;
    op_a_sel_e             op_a_sel;
    op_b_sel_e             op_b_sel;
    op_c_sel_e             op_c_sel;
    imm_sel_e              imm_sel;
    logic [NUM_RS-1:0]     rs_re;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rd;
    logic                  lsu_en;
    logic                  lsu_we;
    logic [LSU_SIZE_W-1:0] lsu_size;
    logic                  lsu_sext;
    logic                  branch;
    logic                  jump;
    logic                  jump_reg;
    logic                  illegal;
  } dec_ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       operand_c;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rf_we;
    logic                  lsu_en;
    logic                  lsu_we;
    logic [LSU_SIZE_W-1:0] lsu_size;
    logic                  lsu_sext;
    logic                  branch;
    logic                  jump;
    logic                  illegal;
  } id_ex_t;

endpackage

// ==== source/rv_decoder.sv ====
// RV32I subset decoder, turns one instruction word into the control record
// Purely combinational, sits between the fetch record and the operand muxes
`timescale 1ns/1ps

module rv_decoder (
  input  logic [decode_pkg::XLEN-1:0] instr_i,
  output decode_pkg::dec_ctrl_t       ctrl_o
);

  logic [decode_pkg::OPC_W-1:0]    opcode;
  logic [decode_pkg::FUNCT3_W-1:0] funct3;
  logic [decode_pkg::FUNCT7_W-1:0] funct7;

  assign opcode = instr_i[decode_pkg::OPC_W-1:0];
  assign funct3 = instr_i[decode_pkg::FUNCT3_LSB +: decode_pkg::FUNCT3_W];
  assign funct7 = instr_i[decode_pkg::FUNCT7_LSB +: decode_pkg::FUNCT7_W];

  // Plain ALU operation per funct3, shared by OP and OP-IMM
  function automatic decode_pkg::alu_op_e alu_base(input logic [2:0] f3);
    case (f3)
      3'b000:  return decode_pkg::ALU_ADD;
      3'b001:  return decode_pkg::ALU_SLL;
      3'b010:  return decode_pkg::ALU_SLT;
      3'b011:  return decode_pkg::ALU_SLTU;
      3'b100:  return decode_pkg::ALU_XOR;
      3'b101:  return decode_pkg::ALU_SRL;
      3'b110:  return decode_pkg::ALU_OR;
      default: return decode_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    // Defaults describe a register-register ADD with no side effects
    ctrl_o          = '0;
    ctrl_o.alu_op   = decode_pkg::ALU_ADD;
    ctrl_o.op_a_sel = decode_pkg::OP_A_REG;
    ctrl_o.op_b_sel = decode_pkg::OP_B_REG;
    ctrl_o.op_c_sel = decode_pkg::OP_C_NONE;
    ctrl_o.imm_sel  = decode_pkg::IMM_I;
    ctrl_o.rd       = instr_i[decode_pkg::RD_LSB +: decode_pkg::REG_ADDR_W];

    case (opcode)
      decode_pkg::OPC_OP: begin
        ctrl_o.rs_re  = '1;
        ctrl_o.rf_we  = 1'b1;
        ctrl_o.alu_op = alu_base(funct3);
        if (funct7 == decode_pkg::F7_ALT) begin
          // Only ADD and SRL have an alternate form
          case (funct3)
            3'b000:  ctrl_o.alu_op  = decode_pkg::ALU_SUB;
            3'b101:  ctrl_o.alu_op  = decode_pkg::ALU_SRA;
            default: ctrl_o.illegal = 1'b1;
          endcase
        end else if (funct7 != decode_pkg::F7_BASE) begin
          ctrl_o.illegal = 1'b1;
        end
      end
      decode_pkg::OPC_OP_IMM: begin
        ctrl_o.rs_re[0] = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_b_sel = decode_pkg::OP_B_IMM;
        ctrl_o.alu_op   = alu_base(funct3);
        // Shift amounts share the upper bits with funct7
        if (funct3 == 3'b101 && funct7 == decode_pkg::F7_ALT) begin
          ctrl_o.alu_op = decode_pkg::ALU_SRA;
        end else if (funct3[1:0] == 2'b01 && funct7 != decode_pkg::F7_BASE) begin
          ctrl_o.illegal = 1'b1;
        end
      end
      decode_pkg::OPC_LUI: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = decode_pkg::OP_A_ZERO;
        ctrl_o.op_b_sel = decode_pkg::OP_B_IMM;
        ctrl_o.imm_sel  = decode_pkg::IMM_U;
      end
      decode_pkg::OPC_AUIPC: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = decode_pkg::OP_A_PC;
        ctrl_o.op_b_sel = decode_pkg::OP_B_IMM;
        ctrl_o.imm_sel  = decode_pkg::IMM_U;
      end
      ////////////////////
      // Memory access
      ////////////////////
      decode_pkg::OPC_LOAD: begin
        ctrl_o.rs_re[0] = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_b_sel = decode_pkg::OP_B_IMM;
        ctrl_o.lsu_en   = 1'b1;
        ctrl_o.lsu_size = funct3[1:0];
        ctrl_o.lsu_sext = ~funct3[2];
        // No doubleword, and no unsigned word on RV32
        ctrl_o.illegal  = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      decode_pkg::OPC_STORE: begin
        ctrl_o.rs_re    = '1;
        ctrl_o.op_b_sel = decode_pkg::OP_B_IMM;
        ctrl_o.op_c_sel = decode_pkg::OP_C_RS2;
        ctrl_o.imm_sel  = decode_pkg::IMM_S;
        ctrl_o.lsu_en   = 1'b1;
        ctrl_o.lsu_we   = 1'b1;
        ctrl_o.lsu_size = funct3[1:0];
        ctrl_o.illegal  = funct3[2] || (funct3[1:0] == 2'b11);
      end
      ////////////////////
      // Control transfer
      ////////////////////
      decode_pkg::OPC_BRANCH: begin
        ctrl_o.rs_re    = '1;
        ctrl_o.op_c_sel = decode_pkg::OP_C_TARGET;
        ctrl_o.imm_sel  = decode_pkg::IMM_B;
        ctrl_o.branch   = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.alu_op  = decode_pkg::ALU_EQ;
          3'b001:  ctrl_o.alu_op  = decode_pkg::ALU_NE;
          3'b100:  ctrl_o.alu_op  = decode_pkg::ALU_LT;
          3'b101:  ctrl_o.alu_op  = decode_pkg::ALU_GE;
          3'b110:  ctrl_o.alu_op  = decode_pkg::ALU_LTU;
          3'b111:  ctrl_o.alu_op  = decode_pkg::ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      decode_pkg::OPC_JAL, decode_pkg::OPC_JALR: begin
        // Link value is pc + 4, target travels in operand C
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = decode_pkg::OP_A_PC;
        ctrl_o.op_b_sel = decode_pkg::OP_B_PCINCR;
        ctrl_o.op_c_sel = decode_pkg::OP_C_TARGET;
        ctrl_o.jump     = 1'b1;
        if (opcode == decode_pkg::OPC_JAL) begin
          ctrl_o.imm_sel = decode_pkg::IMM_J;
        end else begin
          ctrl_o.rs_re[0] = 1'b1;
          ctrl_o.jump_reg = 1'b1;
          ctrl_o.illegal  = (funct3 != 3'b000);
        end
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal encodings leave no writes, no memory access and zero operands
    if (ctrl_o.illegal) begin
      ctrl_o.alu_op   = decode_pkg::ALU_ADD;
      ctrl_o.rs_re    = '0;
      ctrl_o.rf_we    = 1'b0;
      ctrl_o.lsu_en   = 1'b0;
      ctrl_o.lsu_we   = 1'b0;
      ctrl_o.branch   = 1'b0;
      ctrl_o.jump     = 1'b0;
      ctrl_o.jump_reg = 1'b0;
      ctrl_o.op_a_sel = decode_pkg::OP_A_ZERO;
      ctrl_o.op_b_sel = decode_pkg::OP_B_REG;
      ctrl_o.op_c_sel = decode_pkg::OP_C_NONE;
    end
  end

  // EX sees at most one functional unit request per instruction
  a_one_unit: assert final ($onehot0({ctrl_o.lsu_en, ctrl_o.branch, ctrl_o.jump}))
    else $error("decoder requested more than one unit");

endmodule

// ==== source/imm_gen.sv ====
// Immediate extraction for every RV32I format, selected by the decoder
`timescale 1ns/1ps

module imm_gen (
  input  logic [decode_pkg::XLEN-1:0] instr_i,
  input  decode_pkg::imm_sel_e        imm_sel_i,
  output logic [decode_pkg::XLEN-1:0] imm_o
);

  logic [decode_pkg::XLEN-1:0] imm_i_type;
  logic [decode_pkg::XLEN-1:0] imm_s_type;
  logic [decode_pkg::XLEN-1:0] imm_b_type;
  logic [decode_pkg::XLEN-1:0] imm_u_type;
  logic [decode_pkg::XLEN-1:0] imm_j_type;

  // All formats sign extend from bit 31
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

  // Branch and jump offsets are halfword aligned
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                       instr_i[20], instr_i[30:21], 1'b0};

  // Upper immediate fills the low 12 bits with zero
  assign imm_u_type = {instr_i[31:12], 12'b0};

  always_comb begin
    case (imm_sel_i)
      decode_pkg::IMM_S: imm_o = imm_s_type;
      decode_pkg::IMM_B: imm_o = imm_b_type;
      decode_pkg::IMM_U: imm_o = imm_u_type;
      decode_pkg::IMM_J: imm_o = imm_j_type;
      default:           imm_o = imm_i_type;
    endcase
  end

endmodule

// ==== source/operand_bypass.sv ====
// Forwarding selection for one source register
// Priority is x0, then EX result, then WB result, then register file
`timescale 1ns/1ps

module operand_bypass (
  input  logic [decode_pkg::REG_ADDR_W-1:0] raddr_i,
  input  logic [decode_pkg::XLEN-1:0]       rdata_i,
  input  decode_pkg::fwd_src_t              fwd_ex_i,
  input  decode_pkg::fwd_src_t              fwd_wb_i,
  output logic [decode_pkg::XLEN-1:0]       value_o
);

  logic rs_zero;
  logic ex_hit;
  logic wb_hit;

  assign rs_zero = (raddr_i == '0);

  // A stage only forwards when it will actually write that register
  assign ex_hit = fwd_ex_i.we && (fwd_ex_i.waddr == raddr_i);
  assign wb_hit = fwd_wb_i.we && (fwd_wb_i.waddr == raddr_i);

  always_comb begin
    if (rs_zero) begin
      // x0 reads zero even if an older stage claims to write it
      value_o = '0;
    end else if (ex_hit) begin
      value_o = fwd_ex_i.wdata;
    end else if (wb_hit) begin
      value_o = fwd_wb_i.wdata;
    end else begin
      value_o = rdata_i;
    end
  end

  // The youngest writer must win over WB and stale register data
  a_ex_priority: assert final (!(fwd_ex_i.we && fwd_ex_i.waddr == raddr_i && raddr_i != '0)
                               || value_o == fwd_ex_i.wdata)
    else $error("EX forwarding lost priority for x%0d", raddr_i);

endmodule

// ==== source/target_calc.sv ====
// Branch and jump target adder
// PC relative for branches and JAL, register relative for JALR
`timescale 1ns/1ps

module target_calc (
  input  logic [decode_pkg::XLEN-1:0] pc_i,
  input  logic [decode_pkg::XLEN-1:0] rs1_i,
  input  logic [decode_pkg::XLEN-1:0] imm_i,
  input  logic                        jump_reg_i,
  output logic [decode_pkg::XLEN-1:0] target_o
);

  logic [decode_pkg::XLEN-1:0] base;
  logic [decode_pkg::XLEN-1:0] sum;

  // rs1 arrives already forwarded
  assign base = jump_reg_i ? rs1_i : pc_i;
  assign sum  = base + imm_i;

  // JALR clears the lowest bit of the sum
  assign target_o = {sum[decode_pkg::XLEN-1:1], sum[0] & ~jump_reg_i};

endmodule

// ==== source/id_ex_register.sv ====
// Operand selection and the handshaked ID/EX pipeline register
// One cycle of latency, full throughput when EX keeps ready high
`timescale 1ns/1ps

module id_ex_register (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                in_valid_i,
  output logic                                                in_ready_o,
  input  logic [decode_pkg::XLEN-1:0]                         pc_i,
  input  decode_pkg::dec_ctrl_t                               ctrl_i,
  input  logic [decode_pkg::NUM_RS-1:0][decode_pkg::XLEN-1:0] rs_i,
  input  logic [decode_pkg::XLEN-1:0]                         imm_i,
  input  logic [decode_pkg::XLEN-1:0]                         target_i,
  output decode_pkg::id_ex_t                                  id_ex_o,
  output logic                                                out_valid_o,
  input  logic                                                out_ready_i
);

  logic [decode_pkg::NUM_RS-1:0][decode_pkg::XLEN-1:0] rs_used;
  logic [decode_pkg::XLEN-1:0] operand_a;
  logic [decode_pkg::XLEN-1:0] operand_b;
  logic [decode_pkg::XLEN-1:0] operand_c;
  decode_pkg::id_ex_t          id_ex_d;
  logic                        accept;

  ////////////////////
  // Operand muxes
  ////////////////////

  // Sources the decoder does not read contribute zero
  for (genvar g = 0; g < decode_pkg::NUM_RS; g++) begin : g_rs_mask
    assign rs_used[g] = ctrl_i.rs_re[g] ? rs_i[g] : '0;
  end

  always_comb begin
    case (ctrl_i.op_a_sel)
      decode_pkg::OP_A_REG: operand_a = rs_used[0];
      decode_pkg::OP_A_PC:  operand_a = pc_i;
      default:              operand_a = '0;
    endcase

    case (ctrl_i.op_b_sel)
      decode_pkg::OP_B_REG:    operand_b = rs_used[1];
      decode_pkg::OP_B_IMM:    operand_b = imm_i;
      decode_pkg::OP_B_PCINCR: operand_b = decode_pkg::XLEN'(decode_pkg::PC_INCR);
      default:                 operand_b = '0;
    endcase

    // Store data or control transfer target
    case (ctrl_i.op_c_sel)
      decode_pkg::OP_C_RS2:    operand_c = rs_used[1];
      decode_pkg::OP_C_TARGET: operand_c = target_i;
      default:                 operand_c = '0;
    endcase
  end

  always_comb begin
    id_ex_d           = '0;
    id_ex_d.pc        = pc_i;
    id_ex_d.alu_op    = ctrl_i.alu_op;
    id_ex_d.operand_a = operand_a;
    id_ex_d.operand_b = operand_b;
    id_ex_d.operand_c = operand_c;
    id_ex_d.rd        = ctrl_i.rd;
    id_ex_d.rf_we     = ctrl_i.rf_we;
    id_ex_d.lsu_en    = ctrl_i.lsu_en;
    id_ex_d.lsu_we    = ctrl_i.lsu_we;
    id_ex_d.lsu_size  = ctrl_i.lsu_size;
    id_ex_d.lsu_sext  = ctrl_i.lsu_sext;
    id_ex_d.branch    = ctrl_i.branch;
    id_ex_d.jump      = ctrl_i.jump;
    id_ex_d.illegal   = ctrl_i.illegal;
  end

  ////////////////////
  // Handshake
  ////////////////////

  // Register is free when empty or when EX drains it this cycle
  assign in_ready_o = !out_valid_o || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  // Payload only moves on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      id_ex_o <= id_ex_d;
    end
  end

  // A stalled record stays put until EX takes it
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(id_ex_o))
    else $error("ID/EX record changed under back-pressure");

endmodule

// ==== source/decode_stage.sv ====
// Top of the decode stage, takes a fetched instruction and hands a decoded
// record to EX, register file read and forwarding sources come from outside
`timescale 1ns/1ps

module decode_stage (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  input  decode_pkg::if_id_t                                      if_id_i,
  input  logic                                                    in_valid_i,
  output logic                                                    in_ready_o,
  output logic [decode_pkg::NUM_RS-1:0][decode_pkg::REG_ADDR_W-1:0] rf_raddr_o,
  input  logic [decode_pkg::NUM_RS-1:0][decode_pkg::XLEN-1:0]     rf_rdata_i,
  input  decode_pkg::fwd_src_t                                    fwd_ex_i,
  input  decode_pkg::fwd_src_t                                    fwd_wb_i,
  output decode_pkg::id_ex_t                                      id_ex_o,
  output logic                                                    out_valid_o,
  input  logic                                                    out_ready_i
);

  decode_pkg::dec_ctrl_t                               ctrl;
  logic [decode_pkg::NUM_RS-1:0][decode_pkg::XLEN-1:0] rs_value;
  logic [decode_pkg::XLEN-1:0]                         imm;
  logic [decode_pkg::XLEN-1:0]                         target;

  // Register file is read in the same cycle the instruction is offered
  assign rf_raddr_o[0] = if_id_i.instr[decode_pkg::RS1_LSB +: decode_pkg::REG_ADDR_W];
  assign rf_raddr_o[1] = if_id_i.instr[decode_pkg::RS2_LSB +: decode_pkg::REG_ADDR_W];

  rv_decoder u_decoder (
    .instr_i (if_id_i.instr),
    .ctrl_o  (ctrl)
  );

  imm_gen u_imm_gen (
    .instr_i   (if_id_i.instr),
    .imm_sel_i (ctrl.imm_sel),
    .imm_o     (imm)
  );

  // One bypass unit per source register
  for (genvar g = 0; g < decode_pkg::NUM_RS; g++) begin : g_bypass
    operand_bypass u_bypass (
      .raddr_i  (rf_raddr_o[g]),
      .rdata_i  (rf_rdata_i[g]),
      .fwd_ex_i (fwd_ex_i),
      .fwd_wb_i (fwd_wb_i),
      .value_o  (rs_value[g])
    );
  end

  // JALR base is the forwarded rs1
  target_calc u_target (
    .pc_i       (if_id_i.pc),
    .rs1_i      (rs_value[0]),
    .imm_i      (imm),
    .jump_reg_i (ctrl.jump_reg),
    .target_o   (target)
  );

  id_ex_register u_id_ex (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .pc_i        (if_id_i.pc),
    .ctrl_i      (ctrl),
    .rs_i        (rs_value),
    .imm_i       (imm),
    .target_i    (target),
    .id_ex_o     (id_ex_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

endmodule

// ==== sim/decode_stage_tb.sv ====
// Table-driven testbench for the decode stage under random EX back-pressure
// Rows go in one at a time, decoded records are checked in order at the output
`timescale 1ns/1ps

module decode_stage_tb;

  localparam int CYCLES_PER_ROW = 8;
  localparam int EXTRA_CYCLES   = 20;
  localparam decode_pkg::fwd_src_t NO_FWD = '0;

  // One stimulus row with its expected record
  typedef struct packed {
    decode_pkg::if_id_t                                  if_id;
    logic [decode_pkg::NUM_RS-1:0][decode_pkg::XLEN-1:0] rdata;
    decode_pkg::fwd_src_t                                ex;
    decode_pkg::fwd_src_t                                wb;
    decode_pkg::id_ex_t                                  exp;
  } row_t;

  logic clk = 1'b0;
  logic rst_n;
  decode_pkg::if_id_t if_id_i;
  logic in_valid_i;
  logic in_ready_o;
  logic [decode_pkg::NUM_RS-1:0][decode_pkg::REG_ADDR_W-1:0] rf_raddr_o;
  logic [decode_pkg::NUM_RS-1:0][decode_pkg::XLEN-1:0]       rf_rdata_i;
  decode_pkg::fwd_src_t fwd_ex_i;
  decode_pkg::fwd_src_t fwd_wb_i;
  decode_pkg::id_ex_t   id_ex_o;
  logic out_valid_o;
  logic out_ready_i;

  row_t  rows[$];
  string names[$];
  decode_pkg::id_ex_t exp_q[$];
  string exp_name_q[$];
  logic  table_built = 1'b0;
  logic  holding = 1'b0;
  decode_pkg::id_ex_t held;
  logic [15:0] lfsr_state = 16'd4;
  // Occupancy of the ID/EX register as expected, empty out of reset
  logic  exp_full = 1'b0;

  decode_stage UUT (
    .clk(clk), .rst_n(rst_n), .if_id_i(if_id_i), .in_valid_i(in_valid_i),
    .in_ready_o(in_ready_o), .rf_raddr_o(rf_raddr_o), .rf_rdata_i(rf_rdata_i),
    .fwd_ex_i(fwd_ex_i), .fwd_wb_i(fwd_wb_i), .id_ex_o(id_ex_o),
    .out_valid_o(out_valid_o), .out_ready_i(out_ready_i)
  );

  always #10 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_id_ex(input string name, input decode_pkg::id_ex_t exp,
                             input decode_pkg::id_ex_t act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input logic [decode_pkg::REG_ADDR_W-1:0] exp,
                            input logic [decode_pkg::REG_ADDR_W-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // Taps of x^16 + x^14 + x^13 + x^11
  // New bit enters at the bottom
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Instruction encoders per RV32I format
  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, decode_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], decode_pkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], decode_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, decode_pkg::OPC_JAL};
  endfunction

  function automatic decode_pkg::fwd_src_t fwd_source(input logic we, input logic [4:0] addr,
                                                      input logic [31:0] data);
    return {we, addr, data};
  endfunction

  // pc and rd are filled in by add_row from the row itself
  function automatic decode_pkg::id_ex_t make_exp(
    input decode_pkg::alu_op_e alu, input logic [31:0] a, b, c,
    input logic rf_we, lsu_en, lsu_we, input logic [1:0] size,
    input logic sext, branch, jump, illegal);
    decode_pkg::id_ex_t e;
    e           = '0;
    e.alu_op    = alu;
    e.operand_a = a;
    e.operand_b = b;
    e.operand_c = c;
    e.rf_we     = rf_we;
    e.lsu_en    = lsu_en;
    e.lsu_we    = lsu_we;
    e.lsu_size  = size;
    e.lsu_sext  = sext;
    e.branch    = branch;
    e.jump      = jump;
    e.illegal   = illegal;
    return e;
  endfunction

  task automatic add_row(input string name, input logic [31:0] instr, pc, rs1_data, rs2_data,
                         input decode_pkg::fwd_src_t ex, wb, input decode_pkg::id_ex_t exp);
    row_t r;
    r.if_id.pc    = pc;
    r.if_id.instr = instr;
    r.rdata[0]    = rs1_data;
    r.rdata[1]    = rs2_data;
    r.ex          = ex;
    r.wb          = wb;
    r.exp         = exp;
    r.exp.pc      = pc;
    r.exp.rd      = instr[11:7];
    rows.push_back(r);
    names.push_back(name);
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////
  task automatic build_table();
    add_row("add_rf", encode_r(decode_pkg::F7_BASE, 2, 1, 3'b000, 3), 32'h100, 32'h1111_1111,
            32'h2222_2222, NO_FWD, NO_FWD,
            make_exp(decode_pkg::ALU_ADD, 32'h1111_1111, 32'h2222_2222, 0, 1, 0, 0, 0, 0, 0, 0, 0));
    // EX beats WB on the same register
    add_row("sub_ex_over_wb", encode_r(decode_pkg::F7_ALT, 6, 5, 3'b000, 4), 32'h104,
            32'hDEAD_0001, 32'hDEAD_0002, fwd_source(1, 5, 32'hAAAA_0000),
            fwd_source(1, 5, 32'hBBBB_0000),
            make_exp(decode_pkg::ALU_SUB, 32'hAAAA_0000, 32'hDEAD_0002, 0, 1, 0, 0, 0, 0, 0, 0, 0));
    // Disabled EX match must not forward
    add_row("xor_wb", encode_r(decode_pkg::F7_BASE, 6, 5, 3'b100, 4), 32'h108, 32'h0F0F_0F0F,
            32'hDEAD_0003, fwd_source(0, 6, 32'h5555_AAAA), fwd_source(1, 6, 32'h0000_CCCC),
            make_exp(decode_pkg::ALU_XOR, 32'h0F0F_0F0F, 32'h0000_CCCC, 0, 1, 0, 0, 0, 0, 0, 0, 0));
    add_row("sra_x0", encode_r(decode_pkg::F7_ALT, 8, 0, 3'b101, 7), 32'h10C, 32'h1234_5678,
            32'h3, fwd_source(1, 0, 32'hFFFF_FFFF), fwd_source(1, 0, 32'hEEEE_EEEE),
            make_exp(decode_pkg::ALU_SRA, 0, 32'h3, 0, 1, 0, 0, 0, 0, 0, 0, 0));
    add_row("addi_neg", encode_i(12'hFF0, 10, 3'b000, 9, decode_pkg::OPC_OP_IMM), 32'h110,
            32'h1000, 32'h7777, NO_FWD, NO_FWD,
            make_exp(decode_pkg::ALU_ADD, 32'h1000, 32'hFFFF_FFF0, 0, 1, 0, 0, 0, 0, 0, 0, 0));
    add_row("lui", {20'h12345, 5'd11, decode_pkg::OPC_LUI}, 32'h114, 32'h1111, 32'h2222,
            NO_FWD, NO_FWD,
            make_exp(decode_pkg::ALU_ADD, 0, 32'h1234_5000, 0, 1, 0, 0, 0, 0, 0, 0, 0));
    add_row("auipc", {20'hFFFFF, 5'd12, decode_pkg::OPC_AUIPC}, 32'h2000, 32'h1, 32'h2,
            NO_FWD, NO_FWD,
            make_exp(decode_pkg::ALU_ADD, 32'h2000, 32'hFFFF_F000, 0, 1, 0, 0, 0, 0, 0, 0, 0));
    add_row("lh", encode_i(12'hFFC, 14, 3'b001, 13, decode_pkg::OPC_LOAD), 32'h2004, 32'h8000,
            32'h5, NO_FWD, NO_FWD,
            make_exp(decode_pkg::ALU_ADD, 32'h8000, 32'hFFFF_FFFC, 0, 1, 1, 0, 1, 1, 0, 0, 0));
    add_row("lbu", encode_i(12'd7, 16, 3'b100, 15, decode_pkg::OPC_LOAD), 32'h2008, 32'h9000,
            32'h6, NO_FWD, NO_FWD,
            make_exp(decode_pkg::ALU_ADD, 32'h9000, 32'h7, 0, 1, 1, 0, 0, 0, 0, 0, 0));
    // Store data comes from WB, not from the stale register file value
    add_row("sw", encode_s(12'd40, 17, 18, 3'b010), 32'h200C, 32'h3000, 32'h1234,
            NO_FWD, fwd_source(1, 17, 32'hCAFE_F00D),
            make_exp(decode_pkg::ALU_ADD, 32'h3000, 32'd40, 32'hCAFE_F00D, 0, 1, 1, 2, 0, 0, 0, 0));
    add_row("bne_back", encode_b(13'h1FF8, 20, 19, 3'b001), 32'h400, 32'h55, 32'h66,
            NO_FWD, NO_FWD,
            make_exp(decode_pkg::ALU_NE, 32'h55, 32'h66, 32'h3F8, 0, 0, 0, 0, 0, 1, 0, 0));
    add_row("jal", encode_j(21'h000800, 1), 32'h1000, 32'h7, 32'h8, NO_FWD, NO_FWD,
            make_exp(decode_pkg::ALU_ADD, 32'h1000, 32'd4, 32'h1800, 1, 0, 0, 0, 0, 0, 1, 0));
    // Base register forwarded from EX, bit 0 of the target cleared
    add_row("jalr_fwd", encode_i(12'd3, 6, 3'b000, 5, decode_pkg::OPC_JALR), 32'h500, 32'h9999,
            32'h1, fwd_source(1, 6, 32'h4000), NO_FWD,
            make_exp(decode_pkg::ALU_ADD, 32'h500, 32'd4, 32'h4002, 1, 0, 0, 0, 0, 0, 1, 0));
    // CSR write reads x6 and x5, yet every operand must come out zero
    add_row("illegal_sys", 32'h3053_12F3, 32'h600, 32'hAAAA, 32'hBBBB, NO_FWD, NO_FWD,
            make_exp(decode_pkg::ALU_ADD, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1));
  endtask

  ////////////////////
  // Driver
  ////////////////////
  initial begin
    rst_n       = 1'b0;
    if_id_i     = '0;
    in_valid_i  = 1'b0;
    rf_rdata_i  = '0;
    fwd_ex_i    = '0;
    fwd_wb_i    = '0;
    out_ready_i = 1'b0;
    build_table();
    table_built = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // One idle cycle after reset
    @(negedge clk);
    for (int i = 0; i < rows.size(); i++) begin
      if_id_i    = rows[i].if_id;
      rf_rdata_i = rows[i].rdata;
      fwd_ex_i   = rows[i].ex;
      fwd_wb_i   = rows[i].wb;
      in_valid_i = 1'b1;
      exp_q.push_back(rows[i].exp);
      exp_name_q.push_back(names[i]);
      // Hold the row until the stage takes it
      @(posedge clk);
      while (!in_ready_o) @(posedge clk);
      check_addr({names[i], " rs1"}, rows[i].if_id.instr[19:15], rf_raddr_o[0]);
      check_addr({names[i], " rs2"}, rows[i].if_id.instr[24:20], rf_raddr_o[1]);
      @(negedge clk);
    end
    in_valid_i = 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

  // EX readiness takes one LFSR bit per cycle
  always @(negedge clk) begin
    lfsr_state  = lfsr_step(lfsr_state);
    out_ready_i = lfsr_state[0];
  end

  ////////////////////
  // Output monitor
  ////////////////////
  always @(posedge clk) begin
    if (rst_n) begin
      // Handshake flags against the one-entry occupancy model
      check_flag("out_valid", exp_full, out_valid_o);
      check_flag("in_ready", !exp_full || out_ready_i, in_ready_o);
      if (holding) begin
        check_id_ex("hold_stable", held, id_ex_o);
      end
      holding = exp_full && !out_ready_i;
      held    = id_ex_o;
      if (exp_full && out_ready_i) begin
        check_id_ex(exp_name_q.pop_front(), exp_q.pop_front(), id_ex_o);
      end
      // Stays full under back-pressure or refills from a valid input
      exp_full = holding || in_valid_i;
    end
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_built);
    repeat (rows.size() * CYCLES_PER_ROW + EXTRA_CYCLES) @(posedge clk);
    abort_run("the run timed out before all rows came out of the stage");
  end

endmodule

// ==== decode_stage.f ====
source/decode_pkg.sv
source/rv_decoder.sv
source/imm_gen.sv
source/operand_bypass.sv
source/target_calc.sv
source/id_ex_register.sv
source/decode_stage.sv
sim/decode_stage_tb.sv
